//--- Bender.yml
package:
  name: rv_decode

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_decode_pkg.sv
      - hw/rv_imm_gen.sv
      - hw/rv_ctrl_decode.sv
      - hw/rv_decode_issue.sv
      - hw/rv_decode_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/rv_decode_checker.sv
      - testbench/rv_decode_monitor.sv
      - testbench/rv_decode_tb.sv

//--- hw/rv_ctrl_decode.sv
`timescale 1ns/1ps

module rv_ctrl_decode (
    input  rv_decode_pkg::instr_u in_instr,
    output rv_decode_pkg::ctrl_t  ctrl
);

    rv_decode_pkg::opcode_e opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   legal;
    logic                   rs1_use;
    logic                   rs2_use;
    logic                   rd_use;
    rv_decode_pkg::ctrl_t   ops;

    assign opcode = in_instr.r.opcode;
    assign funct3 = in_instr.r.funct3;
    assign funct7 = in_instr.r.funct7;

    // Group decode, sets format usage and the operation fields in ops
    always_comb begin
        legal   = 1'b0;
        rs1_use = 1'b0;
        rs2_use = 1'b0;
        rd_use  = 1'b0;
        ops     = '0;
        ops.alu_op   = rv_decode_pkg::ALU_ADD;
        ops.mem_size = rv_decode_pkg::MEM_BYTE;
        ops.br_cond  = rv_decode_pkg::BR_EQ;
        case (opcode)
            // LUI adds the immediate to a zero operand A
            rv_decode_pkg::OPC_LUI,
            rv_decode_pkg::OPC_AUIPC: begin
                legal        = 1'b1;
                rd_use       = 1'b1;
                ops.op_b_imm = 1'b1;
            end
            rv_decode_pkg::OPC_JAL: begin
                legal        = 1'b1;
                rd_use       = 1'b1;
                ops.op_b_imm = 1'b1;
                ops.is_jump  = 1'b1;
            end
            rv_decode_pkg::OPC_JALR: begin
                legal        = (funct3 == 3'b000);
                rs1_use      = 1'b1;
                rd_use       = 1'b1;
                ops.op_b_imm = 1'b1;
                ops.is_jump  = 1'b1;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                legal         = !(funct3 inside {3'b010, 3'b011});
                rs1_use       = 1'b1;
                rs2_use       = 1'b1;
                ops.is_branch = 1'b1;
                ops.br_cond   = rv_decode_pkg::br_cond_e'(funct3);
            end
            rv_decode_pkg::OPC_LOAD: begin
                legal            = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                rs1_use          = 1'b1;
                rd_use           = 1'b1;
                ops.op_b_imm     = 1'b1;
                ops.mem_read     = 1'b1;
                ops.mem_size     = rv_decode_pkg::mem_size_e'(funct3[1:0]);
                ops.mem_unsigned = funct3[2];
            end
            rv_decode_pkg::OPC_STORE: begin
                legal         = funct3 inside {3'b000, 3'b001, 3'b010};
                rs1_use       = 1'b1;
                rs2_use       = 1'b1;
                ops.op_b_imm  = 1'b1;
                ops.mem_write = 1'b1;
                ops.mem_size  = rv_decode_pkg::mem_size_e'(funct3[1:0]);
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                // Only the shifts put funct7 to use
                case (funct3)
                    rv_decode_pkg::F3_SLL: legal = (funct7 == rv_decode_pkg::F7_BASE);
                    rv_decode_pkg::F3_SR:  legal = funct7 inside {rv_decode_pkg::F7_BASE,
                                                                  rv_decode_pkg::F7_ALT};
                    default:               legal = 1'b1;
                endcase
                rs1_use      = 1'b1;
                rd_use       = 1'b1;
                ops.op_b_imm = 1'b1;
                ops.alu_op   = rv_decode_pkg::alu_op_e'({funct3 == rv_decode_pkg::F3_SR &&
                                                         funct7 == rv_decode_pkg::F7_ALT,
                                                         funct3});
            end
            rv_decode_pkg::OPC_OP: begin
                legal = (funct7 == rv_decode_pkg::F7_BASE) ||
                        (funct7 == rv_decode_pkg::F7_ALT &&
                         funct3 inside {rv_decode_pkg::F3_ADD, rv_decode_pkg::F3_SR});
                rs1_use    = 1'b1;
                rs2_use    = 1'b1;
                rd_use     = 1'b1;
                ops.alu_op = rv_decode_pkg::alu_op_e'({funct7[5], funct3});
            end
            // FENCE, SYSTEM and unknown opcodes stay illegal
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Address fields are zero whenever their enable is low
    always_comb begin
        ctrl         = ops;
        ctrl.illegal = !legal;
        ctrl.rs1_en  = rs1_use;
        ctrl.rs1     = rs1_use ? in_instr.r.rs1 : '0;
        ctrl.rs2_en  = rs2_use;
        ctrl.rs2     = rs2_use ? in_instr.r.rs2 : '0;
        ctrl.rd_we   = rd_use && (in_instr.r.rd != '0);
        ctrl.rd      = rd_use ? in_instr.r.rd : '0;
        if (!legal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

//--- hw/rv_decode_issue.sv
`timescale 1ns/1ps

`include "rv_decode_settings.svh"

module rv_decode_issue (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_decode_pkg::ctrl_t       ctrl,
    input  logic [`RV_XLEN-1:0]        imm,
    input  logic                       out_credit,
    output logic                       in_credit,
    output logic                       out_valid,
    output rv_decode_pkg::dec_bundle_t out_bundle
);

    localparam int DEPTH = `RV_DEC_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [`RV_DEC_CREDIT_W-1:0] CREDIT_MAX = '1;

    rv_decode_pkg::dec_bundle_t  queue [DEPTH];
    rv_decode_pkg::dec_bundle_t  in_bundle;
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [`RV_DEC_CREDIT_W-1:0] q_count;
    logic [`RV_DEC_CREDIT_W-1:0] dn_credit;
    logic                        issue;

    assign in_bundle.ctrl = ctrl;
    assign in_bundle.imm  = imm;

    // Head leaves whenever the consumer has room for it
    assign issue      = (dn_credit != '0) && (q_count != '0);
    assign out_valid  = issue;
    assign in_credit  = issue;
    assign out_bundle = queue[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue[wr_ptr] <= in_bundle;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, issue})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // Downstream credits, saturating in case the consumer overgrants
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dn_credit <= '0;
        end else begin
            case ({out_credit, issue})
                2'b10: begin
                    if (dn_credit != CREDIT_MAX) begin
                        dn_credit <= dn_credit + 1'b1;
                    end
                end
                2'b01:   dn_credit <= dn_credit - 1'b1;
                default: dn_credit <= dn_credit;
            endcase
        end
    end

endmodule

//--- hw/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR  = 3'b101;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Bit 3 is the funct7 alternate bit, bits 2:0 are funct3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcode_e                  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]              imm_11_0;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcode_e                  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]               imm_11_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [4:0]               imm_4_0;
        opcode_e                  opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                     imm_12;
        logic [5:0]               imm_10_5;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [3:0]               imm_4_1;
        logic                     imm_11;
        opcode_e                  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]              imm_31_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcode_e                  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                     imm_20;
        logic [9:0]               imm_10_1;
        logic                     imm_11;
        logic [7:0]               imm_19_12;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcode_e                  opcode;
    } j_fmt_t;

    // One instruction word, read through the view of its format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic                     illegal;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic                     rs1_en;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic                     rs2_en;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic                     rd_we;
        alu_op_e                  alu_op;
        logic                     op_b_imm;
        logic                     mem_read;
        logic                     mem_write;
        mem_size_e                mem_size;
        logic                     mem_unsigned;
        logic                     is_branch;
        br_cond_e                 br_cond;
        logic                     is_jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`RV_XLEN-1:0] imm;
    } dec_bundle_t;

endpackage

//--- hw/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Instruction and data word width
`define RV_XLEN 32

// Register file address width
`define RV_REG_ADDR_W 5

// Bundle queue depth and upstream credits held by the producer after reset
`define RV_DEC_FIFO_DEPTH 4

// Wide enough to count RV_DEC_FIFO_DEPTH entries
`define RV_DEC_CREDIT_W 3

`endif

//--- hw/rv_decode_top.sv
`timescale 1ns/1ps

`include "rv_decode_settings.svh"

module rv_decode_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_decode_pkg::instr_u      in_instr,
    output logic                       in_credit,
    output logic                       out_valid,
    output rv_decode_pkg::dec_bundle_t out_bundle,
    input  logic                       out_credit
);

    rv_decode_pkg::ctrl_t ctrl;
    logic [`RV_XLEN-1:0]  imm;

    rv_imm_gen u_imm_gen (
        .in_instr (in_instr),
        .imm      (imm)
    );

    rv_ctrl_decode u_ctrl_decode (
        .in_instr (in_instr),
        .ctrl     (ctrl)
    );

    rv_decode_issue u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .ctrl       (ctrl),
        .imm        (imm),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_bundle (out_bundle)
    );

endmodule

//--- hw/rv_imm_gen.sv
`timescale 1ns/1ps

`include "rv_decode_settings.svh"

module rv_imm_gen (
    input  rv_decode_pkg::instr_u in_instr,
    output logic [`RV_XLEN-1:0]   imm
);

    localparam int SEXT_I = `RV_XLEN - 12;
    localparam int SEXT_B = `RV_XLEN - 13;
    localparam int SEXT_J = `RV_XLEN - 21;

    always_comb begin
        case (in_instr.i.opcode)
            // Shift immediates keep their funct7 bits here
            rv_decode_pkg::OPC_JALR,
            rv_decode_pkg::OPC_LOAD,
            rv_decode_pkg::OPC_OP_IMM: begin
                imm = {{SEXT_I{in_instr.i.imm_11_0[11]}}, in_instr.i.imm_11_0};
            end
            rv_decode_pkg::OPC_STORE: begin
                imm = {{SEXT_I{in_instr.s.imm_11_5[6]}},
                       in_instr.s.imm_11_5,
                       in_instr.s.imm_4_0};
            end
            rv_decode_pkg::OPC_BRANCH: begin
                imm = {{SEXT_B{in_instr.b.imm_12}},
                       in_instr.b.imm_12,
                       in_instr.b.imm_11,
                       in_instr.b.imm_10_5,
                       in_instr.b.imm_4_1,
                       1'b0};
            end
            // Upper 20 bits, zeros below
            rv_decode_pkg::OPC_LUI,
            rv_decode_pkg::OPC_AUIPC: begin
                imm = {in_instr.u.imm_31_12, 12'b0};
            end
            rv_decode_pkg::OPC_JAL: begin
                imm = {{SEXT_J{in_instr.j.imm_20}},
                       in_instr.j.imm_20,
                       in_instr.j.imm_19_12,
                       in_instr.j.imm_11,
                       in_instr.j.imm_10_1,
                       1'b0};
            end
            // R-type and anything not decoded
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- rv_decode_top.f
+incdir+hw
hw/rv_decode_pkg.sv
hw/rv_imm_gen.sv
hw/rv_ctrl_decode.sv
hw/rv_decode_issue.sv
hw/rv_decode_top.sv
testbench/rv_decode_checker.sv
testbench/rv_decode_monitor.sv
testbench/rv_decode_tb.sv

//--- testbench/rv_decode_checker.sv
`timescale 1ns/1ps

`include "rv_decode_settings.svh"

module rv_decode_checker (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        in_valid,
    input logic                        in_credit,
    input logic                        out_valid,
    input logic                        out_credit,
    input logic [`RV_DEC_CREDIT_W-1:0] q_count
);

    int fail_count = 0;
    int held;

    // Consumer credits not yet spent, counted at the ports
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held <= 0;
        end else begin
            held <= held + int'(out_credit) - int'(out_valid);
        end
    end

    // Issue spends a downstream credit that must already be held
    issue_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> held > 0)
    else begin
        $error("out_valid asserted while the downstream credit counter is zero");
        fail_count++;
    end

    // Every credit sent upstream stands for one bundle leaving the queue
    credit_on_dequeue: assert property (@(posedge clk) disable iff (!arst_n)
        1'b1 |=> int'(q_count) == int'($past(q_count)) + int'($past(in_valid))
                                   - int'($past(in_credit)))
    else begin
        $error("in_credit does not match a bundle leaving the queue");
        fail_count++;
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> q_count < `RV_DEC_FIFO_DEPTH)
    else begin
        $error("instruction accepted while the bundle queue is full");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
        $error("out_valid high during reset");
        fail_count++;
    end

endmodule

//--- testbench/rv_decode_monitor.sv
`timescale 1ns/1ps

module rv_decode_monitor (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  rv_decode_pkg::dec_bundle_t exp_bundle,
    input  string                      exp_name,
    input  logic                       in_credit,
    input  logic                       out_valid,
    input  rv_decode_pkg::dec_bundle_t out_bundle,
    input  logic                       out_credit,
    output int                         received
);

    rv_decode_pkg::dec_bundle_t exp_q[$];
    string                      name_q[$];
    int                         n_out = 0;
    int                         n_in_credit = 0;
    int                         n_granted = 0;
    int                         mismatches = 0;
    int                         stray = 0;
    int                         over_credit = 0;
    int                         credit_errs = 0;

    assign received = n_out;

    always @(posedge clk) begin
        rv_decode_pkg::dec_bundle_t want;
        string                      want_name;
        if (arst_n) begin
            // Pop before push, a bundle cannot leave in the cycle it arrives
            if (out_valid) begin
                n_out++;
                if (n_out > n_granted) begin
                    over_credit++;
                    $display("Bundle %0d issued with only %0d downstream credits granted",
                             n_out, n_granted);
                end
                if (exp_q.size() == 0) begin
                    stray++;
                    $display("Bundle %h came out with no instruction pending", out_bundle);
                end else begin
                    want      = exp_q.pop_front();
                    want_name = name_q.pop_front();
                    if (out_bundle !== want) begin
                        mismatches++;
                        $display("Error: %s expected %h actual %h", want_name, want, out_bundle);
                    end
                end
            end
            if (in_valid) begin
                exp_q.push_back(exp_bundle);
                name_q.push_back(exp_name);
            end
            if (in_credit) begin
                n_in_credit++;
            end
            if (out_credit) begin
                n_granted++;
            end
        end
    end

    task automatic close_out(input int assert_fails, output int total);
        int missing;
        missing = exp_q.size();
        if (missing != 0) begin
            $display("%0d instructions never left the decoder", missing);
        end
        if (n_in_credit != n_out) begin
            credit_errs++;
            $display("in_credit pulsed %0d times for %0d issued bundles", n_in_credit, n_out);
        end
        total = mismatches + stray + over_credit + missing + credit_errs + assert_fails;
        $display("Errors: %0d total, %0d mismatch, %0d unexpected, %0d missing, %0d credit, %0d assertion",
                 total, mismatches, stray, missing, over_credit + credit_errs, assert_fails);
    endtask

endmodule

//--- testbench/rv_decode_tb.sv
`timescale 1ns/1ps

`include "rv_decode_settings.svh"

module rv_decode_tb;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    localparam int          RA_W         = `RV_REG_ADDR_W;
    localparam logic [31:0] SEED         = 32'h3c65_02c0;

    logic                       clk;
    logic                       arst_n;
    logic                       in_valid;
    rv_decode_pkg::instr_u      in_instr;
    logic                       in_credit;
    logic                       out_valid;
    rv_decode_pkg::dec_bundle_t out_bundle;
    logic                       out_credit;

    string                      exp_name;
    rv_decode_pkg::dec_bundle_t exp_bundle;
    string                      tbl_name[$];
    logic [31:0]                tbl_instr[$];
    rv_decode_pkg::dec_bundle_t tbl_exp[$];
    bit                         table_ready = 1'b0;
    int                         spent = 0;
    int                         returned = 0;
    int                         received;
    int                         total_errors;

    rv_decode_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_credit (out_credit)
    );

    rv_decode_monitor u_monitor (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .exp_bundle (exp_bundle),
        .exp_name   (exp_name),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_credit (out_credit),
        .received   (received)
    );

    bind rv_decode_issue rv_decode_checker u_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .q_count    (q_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] r_word(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), RA_W'(rs2), RA_W'(rs1), 3'(f3), RA_W'(rd), rv_decode_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {12'(imm), RA_W'(rs1), 3'(f3), RA_W'(rd), opc};
    endfunction

    function automatic logic [31:0] s_word(int imm, int rs2, int rs1, int f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], RA_W'(rs2), RA_W'(rs1), 3'(f3), v[4:0], rv_decode_pkg::OPC_STORE};
    endfunction

    // Branch offsets are given in bytes and bit 0 is dropped
    function automatic logic [31:0] b_word(int imm, int rs2, int rs1, int f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], RA_W'(rs2), RA_W'(rs1), 3'(f3), v[4:1], v[11],
                rv_decode_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_word(int imm20, int rd, logic [6:0] opc);
        return {20'(imm20), RA_W'(rd), opc};
    endfunction

    function automatic logic [31:0] j_word(int imm, int rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], RA_W'(rd), rv_decode_pkg::OPC_JAL};
    endfunction

    function automatic rv_decode_pkg::ctrl_t op_ctl(int rs1, int rs2, int rd,
                                                     rv_decode_pkg::alu_op_e alu);
        rv_decode_pkg::ctrl_t c;
        c        = '0;
        c.rs1    = RA_W'(rs1);
        c.rs1_en = 1'b1;
        c.rs2    = RA_W'(rs2);
        c.rs2_en = 1'b1;
        c.rd     = RA_W'(rd);
        c.rd_we  = (rd != 0);
        c.alu_op = alu;
        return c;
    endfunction

    function automatic rv_decode_pkg::ctrl_t opimm_ctl(int rs1, int rd,
                                                        rv_decode_pkg::alu_op_e alu);
        rv_decode_pkg::ctrl_t c;
        c          = '0;
        c.rs1      = RA_W'(rs1);
        c.rs1_en   = 1'b1;
        c.rd       = RA_W'(rd);
        c.rd_we    = (rd != 0);
        c.alu_op   = alu;
        c.op_b_imm = 1'b1;
        return c;
    endfunction

    function automatic rv_decode_pkg::ctrl_t load_ctl(int rs1, int rd,
                                                       rv_decode_pkg::mem_size_e size, bit uns);
        rv_decode_pkg::ctrl_t c;
        c              = opimm_ctl(rs1, rd, rv_decode_pkg::ALU_ADD);
        c.mem_read     = 1'b1;
        c.mem_size     = size;
        c.mem_unsigned = uns;
        return c;
    endfunction

    // Stores have no destination and keep rd at zero
    function automatic rv_decode_pkg::ctrl_t store_ctl(int rs1, int rs2,
                                                        rv_decode_pkg::mem_size_e size);
        rv_decode_pkg::ctrl_t c;
        c           = op_ctl(rs1, rs2, 0, rv_decode_pkg::ALU_ADD);
        c.op_b_imm  = 1'b1;
        c.mem_write = 1'b1;
        c.mem_size  = size;
        return c;
    endfunction

    function automatic rv_decode_pkg::ctrl_t branch_ctl(int rs1, int rs2,
                                                         rv_decode_pkg::br_cond_e cond);
        rv_decode_pkg::ctrl_t c;
        c           = op_ctl(rs1, rs2, 0, rv_decode_pkg::ALU_ADD);
        c.is_branch = 1'b1;
        c.br_cond   = cond;
        return c;
    endfunction

    // Operand B of LUI and AUIPC is the upper immediate
    function automatic rv_decode_pkg::ctrl_t upper_ctl(int rd);
        rv_decode_pkg::ctrl_t c;
        c          = '0;
        c.rd       = RA_W'(rd);
        c.rd_we    = (rd != 0);
        c.alu_op   = rv_decode_pkg::ALU_ADD;
        c.op_b_imm = 1'b1;
        return c;
    endfunction

    function automatic rv_decode_pkg::ctrl_t jump_ctl(int rs1, bit rs1_en, int rd);
        rv_decode_pkg::ctrl_t c;
        c         = upper_ctl(rd);
        c.rs1     = RA_W'(rs1);
        c.rs1_en  = rs1_en;
        c.is_jump = 1'b1;
        return c;
    endfunction

    function automatic rv_decode_pkg::ctrl_t illegal_ctl();
        rv_decode_pkg::ctrl_t c;
        c         = '0;
        c.illegal = 1'b1;
        return c;
    endfunction

    task automatic add_test(input string name, input logic [31:0] word,
                            input rv_decode_pkg::ctrl_t ctrl, input logic [31:0] imm);
        rv_decode_pkg::dec_bundle_t b;
        b.ctrl = ctrl;
        b.imm  = imm;
        tbl_name.push_back(name);
        tbl_instr.push_back(word);
        tbl_exp.push_back(b);
    endtask

    task automatic build_table();
        add_test("add", r_word(0, 3, 2, 0, 1), op_ctl(2, 3, 1, rv_decode_pkg::ALU_ADD), 0);
        add_test("sub", r_word(32, 5, 4, 0, 6), op_ctl(4, 5, 6, rv_decode_pkg::ALU_SUB), 0);
        add_test("srl", r_word(0, 9, 8, 5, 7), op_ctl(8, 9, 7, rv_decode_pkg::ALU_SRL), 0);
        add_test("sra", r_word(32, 9, 8, 5, 7), op_ctl(8, 9, 7, rv_decode_pkg::ALU_SRA), 0);
        add_test("sltu", r_word(0, 12, 11, 3, 10),
                 op_ctl(11, 12, 10, rv_decode_pkg::ALU_SLTU), 0);
        add_test("addi_neg", i_word(-1, 1, 0, 2, rv_decode_pkg::OPC_OP_IMM),
                 opimm_ctl(1, 2, rv_decode_pkg::ALU_ADD), 32'hffff_ffff);
        add_test("xori_pos", i_word(12'h7ff, 3, 4, 5, rv_decode_pkg::OPC_OP_IMM),
                 opimm_ctl(3, 5, rv_decode_pkg::ALU_XOR), 32'h0000_07ff);
        add_test("slli", i_word(31, 8, 1, 9, rv_decode_pkg::OPC_OP_IMM),
                 opimm_ctl(8, 9, rv_decode_pkg::ALU_SLL), 32'h0000_001f);
        add_test("srli", i_word(5, 6, 5, 7, rv_decode_pkg::OPC_OP_IMM),
                 opimm_ctl(6, 7, rv_decode_pkg::ALU_SRL), 32'h0000_0005);
        // SRAI carries funct7 0100000 in the immediate
        add_test("srai", i_word(12'h405, 6, 5, 7, rv_decode_pkg::OPC_OP_IMM),
                 opimm_ctl(6, 7, rv_decode_pkg::ALU_SRA), 32'h0000_0405);
        add_test("lb_neg", i_word(-2048, 10, 0, 11, rv_decode_pkg::OPC_LOAD),
                 load_ctl(10, 11, rv_decode_pkg::MEM_BYTE, 1'b0), 32'hffff_f800);
        add_test("lhu", i_word(16, 12, 5, 13, rv_decode_pkg::OPC_LOAD),
                 load_ctl(12, 13, rv_decode_pkg::MEM_HALF, 1'b1), 32'h0000_0010);
        add_test("lw_rd0", i_word(4, 2, 2, 0, rv_decode_pkg::OPC_LOAD),
                 load_ctl(2, 0, rv_decode_pkg::MEM_WORD, 1'b0), 32'h0000_0004);
        add_test("sb_pos", s_word(12'h123, 7, 8, 0),
                 store_ctl(8, 7, rv_decode_pkg::MEM_BYTE), 32'h0000_0123);
        add_test("sw_neg", s_word(-4, 5, 6, 2),
                 store_ctl(6, 5, rv_decode_pkg::MEM_WORD), 32'hffff_fffc);
        add_test("beq_neg", b_word(-16, 2, 1, 0),
                 branch_ctl(1, 2, rv_decode_pkg::BR_EQ), 32'hffff_fff0);
        add_test("blt_bit11", b_word(2048, 6, 5, 4),
                 branch_ctl(5, 6, rv_decode_pkg::BR_LT), 32'h0000_0800);
        add_test("bgeu_max", b_word(4094, 4, 3, 7),
                 branch_ctl(3, 4, rv_decode_pkg::BR_GEU), 32'h0000_0ffe);
        add_test("lui", u_word(20'h12345, 3, rv_decode_pkg::OPC_LUI), upper_ctl(3),
                 32'h1234_5000);
        add_test("auipc_neg", u_word(20'hfffff, 4, rv_decode_pkg::OPC_AUIPC), upper_ctl(4),
                 32'hffff_f000);
        add_test("jal_neg", j_word(-4, 1), jump_ctl(0, 1'b0, 1), 32'hffff_fffc);
        add_test("jal_pos", j_word(32'h000a_bcde, 5), jump_ctl(0, 1'b0, 5), 32'h000a_bcde);
        add_test("jalr", i_word(16, 6, 0, 1, rv_decode_pkg::OPC_JALR), jump_ctl(6, 1'b1, 1),
                 32'h0000_0010);
        add_test("fence", 32'h0ff0_000f, illegal_ctl(), 0);
        add_test("ecall", 32'h0000_0073, illegal_ctl(), 0);
        add_test("bad_opcode", 32'h1234_567b, illegal_ctl(), 0);
        // The immediate still follows the opcode on illegal branches
        add_test("br_f3_010", b_word(8, 2, 1, 2), illegal_ctl(), 32'h0000_0008);
        add_test("br_f3_011", b_word(-2, 2, 1, 3), illegal_ctl(), 32'hffff_fffe);
        add_test("add_bad_f7", r_word(1, 2, 1, 0, 3), illegal_ctl(), 0);
    endtask

    always @(posedge clk) begin
        if (arst_n && in_credit) begin
            returned++;
        end
    end

    // Producer sends one instruction per credit held
    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_credit = 1'b0;
        exp_name   = "";
        exp_bundle = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < tbl_name.size(); i++) begin
            while (spent - returned >= `RV_DEC_FIFO_DEPTH) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid   = 1'b1;
            in_instr   = tbl_instr[i];
            exp_name   = tbl_name[i];
            exp_bundle = tbl_exp[i];
            spent++;
            @(negedge clk);
        end
        in_valid = 1'b0;
        while (received < tbl_name.size()) begin
            @(posedge clk);
        end
        // A few more cycles to catch extra bundles
        repeat (10) @(posedge clk);
        u_monitor.close_out(DUT.u_issue.u_checker.fail_count, total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Consumer credits with random gaps of zero to five cycles
    initial begin
        int gap;
        void'($urandom(SEED));
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            out_credit = 1'b1;
            gap = $urandom_range(5, 0);
            repeat (gap) begin
                @(negedge clk);
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = tbl_name.size() * 8 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, only %0d of %0d instructions left the decoder",
                 limit, received, tbl_name.size());
        $display("Regression failed");
        $finish;
    end

endmodule
